/* tb_ddc_input.txt */
# columns: i value, q value, sample count, gap mode
# signed 18-bit decimals; count is a multiple of 200; gap 1 adds 0..3 idle cycles
# quiet start
0 0 1200 0
0 0 1200 1
# smallest steps
1 1 1400 0
-1 -1 1400 1
2 -3 1200 0
# ordinary levels
1000 -1000 1600 0
-1000 1000 1600 1
25000 25000 1200 0
-25000 -25000 1400 1
# full scale
131071 131071 1600 0
-131072 -131072 1600 1
131071 -131072 1400 0
-131072 131071 1400 1
131070 -131071 1200 0
# one channel idle
0 50000 1200 0
-75000 0 1200 1
0 -131072 1400 0
131071 0 1400 1
# independent levels
12345 -54321 1400 0
-99999 77777 1200 1
256 -256 1200 0
-257 255 1400 1
65536 -65536 1600 0
-65537 65535 1200 1
# back to rest and out again
0 0 1200 0
100000 -100000 1400 0
-3 7 1200 1
42 -42 1200 0
-118000 119000 1400 1
0 0 1200 1

/* build.f */
ddc_pkg.sv
rate_strobe_gen.sv
cic_decimator.sv
ddc_receiver.sv
tb_ddc_receiver.sv

/* Makefile */
# Verilator build and run for the CIC decimating receiver

VERILATOR ?= verilator
TOP       ?= tb_ddc_receiver
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SEED      ?= 44099
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG SEED VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Something failed" $(LOG); then \
		echo "test failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Everything OK" $(LOG); then \
		echo "test ended without a result line, see $(LOG)"; exit 1; \
	fi
	@echo "test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_ddc_receiver.sv */
module tb_ddc_receiver
  import ddc_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int max_segs    = 64;
  localparam int frame_len   = s1_rate * s2_rate;  // input samples per output
  localparam int settle_outs = 5;                  // transient outputs after a step
  localparam int wait_limit  = 1000;               // cycles per wait for a pulse

  logic    clock;
  logic    rst;
  logic    in_valid;
  iq_in_t  in_data;
  logic    out_valid;
  iq_out_t out_data;

  // segment table from the data file
  int seg_i   [max_segs];
  int seg_q   [max_segs];
  int seg_cnt [max_segs];
  int seg_gap [max_segs];
  int n_segs;

  int          cycle = 0;        // rising edges so far
  int          due_q [$];        // cycle in which each pulse must show up
  int          pulse_total = 0;  // every pulse seen, checked against the file
  int          expected_total;
  logic        last_valid;
  out_sample_t held_i;           // output pair as of the last pulse
  out_sample_t held_q;

  int value_errors;
  int protocol_errors;
  int timeout_errors;
  int file_errors;

  ddc_receiver dut_i (
    .clock     (clock),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #10 clock = ~clock;
    end
  end

  always @(posedge clock) begin
    cycle <= cycle + 1;
  end

  always @(negedge clock) begin
    if (out_valid) begin
      pulse_total <= pulse_total + 1;
    end
  end

  // settled DC response, stage 1 gain 10^3 over 2^8, stage 2 gain 20^5 over 2^18
  function automatic longint dc_rule(longint x);
    longint mid;
    mid = (x * 1000) >>> 8;  // floor of the exact product
    return (mid * 3200000) >>> 18;
  endfunction

  task automatic load_segments();
    int    fd;
    int    n;
    int    a;
    int    b;
    int    c;
    int    d;
    string line;
    n_segs = 0;
    fd = $fopen("tb_ddc_input.txt", "r");
    if (fd == 0) begin
      $display("could not open tb_ddc_input.txt for reading");
      file_errors++;
      return;
    end
    while (!$feof(fd) && n_segs < max_segs) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line[0] != "#") begin  // skip comment lines
        n = $sscanf(line, "%d %d %d %d", a, b, c, d);
        if (n == 4) begin
          if (c <= 0 || c % frame_len != 0) begin
            $display("segment line with count %0d is not a multiple of %0d", c, frame_len);
            file_errors++;
          end else begin
            seg_i[n_segs]   = a;
            seg_q[n_segs]   = b;
            seg_cnt[n_segs] = c;
            seg_gap[n_segs] = d;
            n_segs++;
          end
        end
      end
    end
    $fclose(fd);
    if (n_segs == 0) begin
      $display("no segments found in tb_ddc_input.txt");
      file_errors++;
    end
  endtask

  task automatic drive_segments();
    int accepted;
    int gap;
    accepted = 0;
    for (int s = 0; s < n_segs; s++) begin
      for (int k = 0; k < seg_cnt[s]; k++) begin
        @(negedge clock);
        in_valid  = 1'b1;
        in_data.i = in_sample_t'(seg_i[s]);
        in_data.q = in_sample_t'(seg_q[s]);
        accepted++;
        if (accepted % frame_len == 0) begin
          due_q.push_back(cycle + 2);  // taken next edge, pulse one edge later
        end
        if (seg_gap[s] != 0) begin
          gap = $urandom % 4;
          for (int g = 0; g < gap; g++) begin
            @(negedge clock);
            in_valid  = 1'b0;
            in_data.i = in_sample_t'($urandom);  // junk, must be ignored
            in_data.q = in_sample_t'($urandom);
          end
        end
      end
    end
    @(negedge clock);
    in_valid = 1'b0;
    in_data  = '0;
  endtask

  // polls on falling edges, also watches the hold and single-pulse rules
  task automatic wait_for_pulse(output logic found);
    int waited;
    found  = 1'b0;
    waited = 0;
    while (!found && waited < wait_limit) begin
      @(negedge clock);
      waited++;
      if (out_valid) begin
        if (last_valid) begin
          $display("FAIL at %0t: out_valid high in two consecutive cycles", $time);
          protocol_errors++;
        end
        found = 1'b1;
      end else if (out_data.i !== held_i || out_data.q !== held_q) begin
        $display("FAIL at %0t: out_data changed between pulses", $time);
        protocol_errors++;
      end
      last_valid = out_valid;
    end
  endtask

  task automatic check_value(string chan, int seg, longint expected, out_sample_t observed);
    if (longint'(observed) != expected) begin
      $display("FAIL at %0t: segment %0d channel %s expected %0d observed %0d",
               $time, seg, chan, expected, observed);
      value_errors++;
    end
  endtask

  // transient values stay between the old and the new settled level
  task automatic check_between(string chan, int seg, longint a, longint b,
                               out_sample_t observed);
    longint lo;
    longint hi;
    lo = (a < b) ? a : b;
    hi = (a < b) ? b : a;
    if (longint'(observed) < lo || longint'(observed) > hi) begin
      $display("FAIL at %0t: segment %0d channel %s expected %0d..%0d observed %0d",
               $time, seg, chan, lo, hi, observed);
      value_errors++;
    end
  endtask

  task automatic check_segments();
    longint exp_i;
    longint exp_q;
    longint prev_i;
    longint prev_q;
    longint lim;
    logic   found;
    int     due;
    prev_i = 0;  // reset state equals an all-zero history
    prev_q = 0;
    lim    = longint'(1) <<< (out_width - 1);
    for (int s = 0; s < n_segs; s++) begin
      exp_i = dc_rule(seg_i[s]);
      exp_q = dc_rule(seg_q[s]);
      if (exp_i < -lim || exp_i >= lim || exp_q < -lim || exp_q >= lim) begin
        $display("FAIL at %0t: segment %0d rule value outside the 24-bit range", $time, s);
        value_errors++;
      end
      for (int j = 0; j < seg_cnt[s] / frame_len; j++) begin
        wait_for_pulse(found);
        if (!found) begin
          $display("timeout: no out_valid within %0d cycles, segment %0d output %0d",
                   wait_limit, s, j);
          timeout_errors++;
          return;
        end
        if (due_q.size() == 0) begin
          $display("FAIL at %0t: out_valid pulse before its 200th sample", $time);
          protocol_errors++;
        end else begin
          due = due_q.pop_front();
          if (cycle != due) begin
            $display("FAIL at %0t: out_valid in cycle %0d, expected cycle %0d",
                     $time, cycle, due);
            protocol_errors++;
          end
        end
        if (j >= settle_outs) begin
          check_value("I", s, exp_i, out_data.i);
          check_value("Q", s, exp_q, out_data.q);
        end else begin
          check_between("I", s, prev_i, exp_i, out_data.i);
          check_between("Q", s, prev_q, exp_q, out_data.q);
        end
        held_i = out_data.i;
        held_q = out_data.q;
      end
      prev_i = exp_i;
      prev_q = exp_q;
    end
  endtask

  initial begin
    void'($urandom(44099));
    rst             = 1'b1;
    in_valid        = 1'b0;
    in_data         = '0;
    value_errors    = 0;
    protocol_errors = 0;
    timeout_errors  = 0;
    file_errors     = 0;
    expected_total  = 0;
    last_valid      = 1'b0;
    held_i          = '0;
    held_q          = '0;
    load_segments();
    for (int s = 0; s < n_segs; s++) begin
      expected_total += seg_cnt[s] / frame_len;
    end

    repeat (2) @(posedge clock);
    @(negedge clock);
    rst = 1'b0;
    if (out_valid !== 1'b0 || out_data !== '0) begin
      $display("FAIL at %0t: outputs not cleared by reset", $time);
      protocol_errors++;
    end

    fork
      drive_segments();
      check_segments();
    join

    // idle tail, nothing more may come out
    for (int t = 0; t < 50; t++) begin
      @(negedge clock);
    end
    if (pulse_total != expected_total || due_q.size() != 0) begin
      $display("FAIL at %0t: saw %0d out_valid pulses, expected %0d", $time,
               pulse_total, expected_total);
      protocol_errors++;
    end

    $display("errors: value %0d, protocol %0d, timeout %0d, file %0d",
             value_errors, protocol_errors, timeout_errors, file_errors);
    if (value_errors + protocol_errors + timeout_errors + file_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* ddc_receiver.sv */
module ddc_receiver
  import ddc_pkg::*;
(
  input  logic    clock,
  input  logic    rst,
  input  logic    in_valid,   // sample taken on every high cycle
  input  iq_in_t  in_data,
  output logic    out_valid,  // one-cycle pulse per 200 input samples
  output iq_out_t out_data    // held until the next pulse
);

  logic        s1_dec;     // stage-1 output strobe, also stage-2 input enable
  logic        s2_dec;     // stage-2 output strobe
  logic        s2_dec_q;   // s2_dec aligned with the comb output register
  mid_sample_t mid_i;      // stage-1 outputs
  mid_sample_t mid_q;
  out_sample_t dec_i;      // stage-2 outputs
  out_sample_t dec_q;

  rate_strobe_gen strobe_i (
    .clock    (clock),
    .rst      (rst),
    .in_valid (in_valid),
    .s1_dec   (s1_dec),
    .s2_dec   (s2_dec)
  );

  // stage 1 runs at the input rate, I and Q
  cic_decimator #(
    .stages    (s1_stages),
    .acc_width (s1_acc_width),
    .in_w      (in_width),
    .out_w     (mid_width)
  ) s1_i_i (
    .clock    (clock),
    .rst      (rst),
    .in_en    (in_valid),
    .dec      (s1_dec),
    .in_data  (in_data.i),
    .out_data (mid_i)
  );

  cic_decimator #(
    .stages    (s1_stages),
    .acc_width (s1_acc_width),
    .in_w      (in_width),
    .out_w     (mid_width)
  ) s1_q_i (
    .clock    (clock),
    .rst      (rst),
    .in_en    (in_valid),
    .dec      (s1_dec),
    .in_data  (in_data.q),
    .out_data (mid_q)
  );

  // stage 2 integrates once per stage-1 output
  cic_decimator #(
    .stages    (s2_stages),
    .acc_width (s2_acc_width),
    .in_w      (mid_width),
    .out_w     (out_width)
  ) s2_i_i (
    .clock    (clock),
    .rst      (rst),
    .in_en    (s1_dec),
    .dec      (s2_dec),
    .in_data  (mid_i),
    .out_data (dec_i)
  );

  cic_decimator #(
    .stages    (s2_stages),
    .acc_width (s2_acc_width),
    .in_w      (mid_width),
    .out_w     (out_width)
  ) s2_q_i (
    .clock    (clock),
    .rst      (rst),
    .in_en    (s1_dec),
    .dec      (s2_dec),
    .in_data  (mid_q),
    .out_data (dec_q)
  );

  // output register, loads the cycle after the stage-2 comb update
  always_ff @(posedge clock) begin
    if (rst) begin
      s2_dec_q  <= 1'b0;
      out_valid <= 1'b0;
      out_data  <= '0;
    end else begin
      s2_dec_q  <= s2_dec;    // comb result is ready one cycle later
      out_valid <= s2_dec_q;  // single pulse
      if (s2_dec_q) begin
        out_data.i <= dec_i;
        out_data.q <= dec_q;
      end
    end
  end

  // 200 samples apart at the least, so pulses never touch
  a_valid_pulse : assert property (@(posedge clock) disable iff (rst)
    out_valid |=> !out_valid);

endmodule

/* cic_decimator.sv */
module cic_decimator
  import ddc_pkg::*;
#(
  parameter int stages    = s1_stages,     // integrator and comb count
  parameter int acc_width = s1_acc_width,  // full register width
  parameter int in_w      = in_width,
  parameter int out_w     = mid_width
) (
  input  logic                    clock,
  input  logic                    rst,
  input  logic                    in_en,    // input sample strobe
  input  logic                    dec,      // decimation strobe
  input  logic signed [in_w-1:0]  in_data,
  output logic signed [out_w-1:0] out_data  // held between decimated outputs
);

  typedef logic signed [acc_width-1:0] acc_t;

  acc_t integ_in   [stages];    // input side of each integrator
  acc_t integ      [stages];    // integrator registers, input rate
  acc_t comb_x     [stages+1];  // comb chain, comb_x[0] from last integrator
  acc_t comb_dly   [stages];    // previous decimated value per comb

  // integrator chain
  // every integrator adds the previous stage's registered value, so a new
  // sample walks one stage per enable, all in modulo acc_width arithmetic
  for (genvar k = 0; k < stages; k++) begin : g_integ
    if (k == 0) begin : g_head
      // sign extension up to the full width
      assign integ_in[k] = {{(acc_width-in_w){in_data[in_w-1]}}, in_data};
    end else begin : g_tail
      assign integ_in[k] = integ[k-1];
    end

    always_ff @(posedge clock) begin
      if (rst) begin
        integ[k] <= '0;
      end else if (in_en) begin
        integ[k] <= integ[k] + integ_in[k];  // wraps modulo 2^acc_width
      end
    end
  end

  // comb chain at the decimated rate
  assign comb_x[0] = integ[stages-1];

  for (genvar k = 0; k < stages; k++) begin : g_comb
    // difference against the value this stage saw one output ago
    assign comb_x[k+1] = comb_x[k] - comb_dly[k];

    always_ff @(posedge clock) begin
      if (rst) begin
        comb_dly[k] <= '0;
      end else if (dec) begin
        comb_dly[k] <= comb_x[k];  // one register per comb
      end
    end
  end

  // output stage
  // keep the top out_w bits of the last comb, the same as an arithmetic
  // shift right by acc_width - out_w, no rounding
  always_ff @(posedge clock) begin
    if (rst) begin
      out_data <= '0;
    end else if (dec) begin
      out_data <= comb_x[stages][acc_width-1 -: out_w];
    end
  end

  // strobes from the rate generator settle before reset is released
  a_no_dec_in_rst : assert property (@(posedge clock)
    rst |-> !dec);

endmodule

/* rate_strobe_gen.sv */
module rate_strobe_gen
  import ddc_pkg::*;
(
  input  logic clock,
  input  logic rst,
  input  logic in_valid,   // one accepted sample per high cycle
  output logic s1_dec,     // every 10th sample
  output logic s2_dec      // every 200th sample
);

  s1_cnt_t s1_cnt;  // input samples within the stage-1 frame
  s2_cnt_t s2_cnt;  // stage-1 outputs within the stage-2 frame

  // strobes sit in the same cycle as the sample that completes the frame
  assign s1_dec = in_valid && (s1_cnt == s1_cnt_t'(s1_rate - 1));
  assign s2_dec = s1_dec && (s2_cnt == s2_cnt_t'(s2_rate - 1));

  always_ff @(posedge clock) begin
    if (rst) begin
      s1_cnt <= '0;
      s2_cnt <= '0;
    end else begin
      // idle cycles leave both counters alone
      if (in_valid) begin
        s1_cnt <= s1_dec ? '0 : s1_cnt + 1'b1;  // wrap at rate
      end
      // second counter only steps on stage-1 outputs
      if (s1_dec) begin
        s2_cnt <= s2_dec ? '0 : s2_cnt + 1'b1;
      end
    end
  end

  // stage-1 counter has wrapped after a strobe, so strobes never touch
  a_s1_dec_spaced : assert property (@(posedge clock) disable iff (rst)
    s1_dec |=> !s1_dec);

  // counters never leave their modulus
  a_s1_cnt_range : assert property (@(posedge clock) disable iff (rst)
    s1_cnt < s1_rate);
  a_s2_cnt_range : assert property (@(posedge clock) disable iff (rst)
    s2_cnt < s2_rate);

endmodule

/* ddc_pkg.sv */
package ddc_pkg;

  // sample widths along the chain
  localparam int in_width  = 18;  // mixer samples
  localparam int mid_width = 20;  // stage-1 output
  localparam int out_width = 24;  // receiver output

  // stage 1, coarse decimation
  localparam int s1_stages = 3;
  localparam int s1_rate   = 10;

  // stage 2, fine decimation
  localparam int s2_stages = 5;
  localparam int s2_rate   = 20;

  // full register widths, input width plus ceil(stages * log2 rate)
  localparam int s1_acc_width = 28;  // 18 + 10
  localparam int s2_acc_width = 42;  // 20 + 22

  // strobe counter widths
  localparam int s1_cnt_width = $clog2(s1_rate);
  localparam int s2_cnt_width = $clog2(s2_rate);

  // signed samples at each rate
  typedef logic signed [in_width-1:0]  in_sample_t;
  typedef logic signed [mid_width-1:0] mid_sample_t;
  typedef logic signed [out_width-1:0] out_sample_t;

  // decimation phase counters
  typedef logic [s1_cnt_width-1:0] s1_cnt_t;
  typedef logic [s2_cnt_width-1:0] s2_cnt_t;

  // complex pair at the input, i in the upper half
  typedef struct packed {
    in_sample_t i;
    in_sample_t q;
  } iq_in_t;

  // complex pair at the output
  typedef struct packed {
    out_sample_t i;
    out_sample_t q;
  } iq_out_t;

endpackage
